/* Makefile */
# Verilator build and run of the load-use hazard testbench
# usage: make [LOAD_LATENCY=2], make lint, make clean

VERILATOR    ?= verilator
TOP          ?= hazard_tb
FILELIST     ?= files.f
LOAD_LATENCY ?= 1
BUILD_DIR    ?= obj_dir
LOG          ?= sim.log
PASS_TEXT    ?= Testbench passed
VFLAGS       ?= --binary --timing --assert
RUN_FLAGS    ?= +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GLOAD_LATENCY=$(LOAD_LATENCY) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) \
		-GLOAD_LATENCY=$(LOAD_LATENCY) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* files.f */
verilog/hazard_pkg.sv
verilog/id_stage_reg.sv
verilog/instr_decode.sv
verilog/pending_writes.sv
verilog/id_stall.sv
verilog/hazard_top.sv
tb/hazard_chk.sv
tb/hazard_tb.sv

/* tb/hazard_chk.sv */
module hazard_chk (
    input logic        clk,
    input logic        rst_n,
    input logic        fetch_hold,
    input logic        id_valid,
    input logic        issue_valid,
    input logic [63:0] id_pc
);

    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    // a hold is only ever caused by an instruction sitting in ID
    hold_needs_id: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_hold |-> id_valid)
        else begin
            fail_count++;
            $error("fetch_hold high with an empty ID stage");
        end

    hold_gives_bubble: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_hold |=> !issue_valid)
        else begin
            fail_count++;
            $error("issue_valid high in the cycle after a hold");
        end

    hold_keeps_pc: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_hold |=> $stable(id_pc))
        else begin
            fail_count++;
            $error("id_pc changed across a held cycle");
        end

endmodule

bind hazard_top hazard_chk hazard_chk_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .fetch_hold  (fetch_hold),
    .id_valid    (id_valid),
    .issue_valid (issue_valid),
    .id_pc       (id_pc)
);

/* tb/hazard_tb.sv */
module hazard_tb import hazard_pkg::*; #(
    parameter int LOAD_LATENCY = 1
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_ENTRIES  = 20;
    localparam int HOLD_TIMEOUT = 20;

    // one row of the stimulus table, group_end is followed by filler
    typedef struct packed {
        opcode_e    opc;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic       group_end;
    } entry_t;

    logic        clk;
    logic        rst_n;
    logic        instr_valid;
    logic [31:0] instr;
    logic [63:0] pc;
    logic        fetch_hold;
    logic        issue_valid;
    logic [63:0] issue_pc;
    logic [4:0]  issue_rd;
    op_class_e   issue_class;

    entry_t      stim [NUM_ENTRIES];
    int          ready [32];
    int          prev_ex;
    logic [63:0] next_pc;
    logic [31:0] lcg_state;
    logic        have_prev;
    logic [63:0] prev_pc;
    logic [4:0]  prev_rd;
    op_class_e   prev_cls;
    logic        timed_out;
    int          checks;
    int          errors;
    int          timeouts;

    hazard_top #(
        .LOAD_LATENCY (LOAD_LATENCY)
    ) dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .fetch_hold  (fetch_hold),
        .issue_valid (issue_valid),
        .issue_pc    (issue_pc),
        .issue_rd    (issue_rd),
        .issue_class (issue_class)
    );

    always #20 clk = ~clk;

    // class and register use of each format, taken from the ISA
    function automatic op_class_e class_of(input opcode_e opc);
        case (opc)
            OPC_LOAD:   return CLS_LOAD;
            OPC_STORE:  return CLS_STORE;
            OPC_BRANCH: return CLS_BRANCH;
            default:    return CLS_ALU;
        endcase
    endfunction

    function automatic logic reads_rs1(input opcode_e opc);
        return !(opc == OPC_LUI || opc == OPC_JAL);
    endfunction

    function automatic logic reads_rs2(input opcode_e opc);
        return opc == OPC_OP || opc == OPC_STORE || opc == OPC_BRANCH;
    endfunction

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic check_issue();
        checks++;
        assert (issue_valid && issue_pc == prev_pc && issue_rd == prev_rd
                && issue_class == prev_cls) else begin
            errors++;
            $display("[ERROR] %0d ns: issue %0b pc %h rd %0d %s, want pc %h rd %0d %s",
                     $time, issue_valid, issue_pc, issue_rd, issue_class.name(),
                     prev_pc, prev_rd, prev_cls.name());
        end
    endtask

    task automatic check_idle();
        checks++;
        assert (!fetch_hold && !issue_valid) else begin
            errors++;
            $display("[ERROR] %0d ns: fetch_hold %0b issue_valid %0b while idle",
                     $time, fetch_hold, issue_valid);
        end
    endtask

    // presents one word, checks the previous issue and counts held cycles
    task automatic send(input opcode_e opc, input logic [4:0] rd,
                        input logic [4:0] rs1, input logic [4:0] rs2);
        int        arrive;
        int        leave;
        int        stalls;
        logic [4:0] exp_rd;
        op_class_e cls;
        cls    = class_of(opc);
        exp_rd = (cls == CLS_STORE || cls == CLS_BRANCH) ? 5'd0 : rd;
        // ID is left once every load feeding a used source is out of its window
        arrive = prev_ex;
        leave  = arrive;
        if (reads_rs1(opc) && rs1 != 5'd0 && ready[rs1] > leave) begin
            leave = ready[rs1];
        end
        if (reads_rs2(opc) && rs2 != 5'd0 && ready[rs2] > leave) begin
            leave = ready[rs2];
        end
        prev_ex = leave + 1;
        if (cls == CLS_LOAD) begin
            ready[rd] = prev_ex + LOAD_LATENCY;
        end
        instr_valid = 1'b1;
        instr       = {7'b0, rs2, rs1, 3'b0, rd, opc};
        pc          = next_pc;
        @(negedge clk);
        if (have_prev) begin
            check_issue();
        end
        stalls = 0;
        while (fetch_hold && stalls < HOLD_TIMEOUT) begin
            @(negedge clk);
            stalls++;
            // each held cycle leaves a bubble in EX
            checks++;
            assert (!issue_valid) else begin
                errors++;
                $display("[ERROR] %0d ns: issue_valid high after a held cycle", $time);
            end
        end
        if (fetch_hold) begin
            timeouts++;
            timed_out = 1'b1;
            $display("fetch_hold never released for pc %h within %0d cycles",
                     next_pc, HOLD_TIMEOUT);
        end else begin
            checks++;
            assert (stalls == leave - arrive) else begin
                errors++;
                $display("[ERROR] %0d ns: pc %h stalled %0d cycles, expected %0d",
                         $time, next_pc, stalls, leave - arrive);
            end
        end
        have_prev = 1'b1;
        prev_pc   = next_pc;
        prev_rd   = exp_rd;
        prev_cls  = cls;
        next_pc   = next_pc + 64'd4;
    endtask

    // independent ALU work on x20 to x31, registers the table never uses
    task automatic send_filler();
        logic [31:0] r;
        r = next_random();
        send(r[28] ? OPC_OP : OPC_OP_IMM,
             5'(20 + int'(r[15:12]) % 12),
             5'(20 + int'(r[19:16]) % 12),
             5'(20 + int'(r[23:20]) % 12));
    endtask

    task automatic drain();
        instr_valid = 1'b0;
        @(negedge clk);
        check_issue();
        @(negedge clk);
        check_idle();
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        prev_ex     = 0;
        next_pc     = 64'h0000_0000_8000_0000;
        lcg_state   = 32'd75;
        have_prev   = 1'b0;
        timed_out   = 1'b0;
        checks      = 0;
        errors      = 0;
        timeouts    = 0;
        for (int r = 0; r < 32; r++) begin
            ready[r] = -1000;
        end
        stim = '{
            // load, then a reader through rs1 and through rs2
            '{OPC_LOAD,   5'd5,  5'd1,  5'd0,  1'b0},
            '{OPC_OP,     5'd6,  5'd5,  5'd2,  1'b1},
            '{OPC_LOAD,   5'd7,  5'd1,  5'd0,  1'b0},
            '{OPC_OP,     5'd8,  5'd3,  5'd7,  1'b1},
            // store data and branch operand read through rs2
            '{OPC_LOAD,   5'd9,  5'd1,  5'd0,  1'b0},
            '{OPC_STORE,  5'd9,  5'd2,  5'd9,  1'b1},
            '{OPC_LOAD,   5'd10, 5'd1,  5'd0,  1'b0},
            '{OPC_BRANCH, 5'd3,  5'd1,  5'd10, 1'b1},
            // reader two slots behind the load
            '{OPC_LOAD,   5'd11, 5'd1,  5'd0,  1'b0},
            '{OPC_OP_IMM, 5'd12, 5'd1,  5'd0,  1'b0},
            '{OPC_OP,     5'd13, 5'd11, 5'd2,  1'b1},
            // ALU producer is forwarded
            '{OPC_OP,     5'd14, 5'd1,  5'd2,  1'b0},
            '{OPC_OP,     5'd15, 5'd14, 5'd14, 1'b1},
            // x0 as load target and as source
            '{OPC_LOAD,   5'd0,  5'd1,  5'd0,  1'b0},
            '{OPC_OP,     5'd16, 5'd0,  5'd0,  1'b1},
            // immediate bits that look like the load rd
            '{OPC_LOAD,   5'd17, 5'd1,  5'd0,  1'b0},
            '{OPC_OP_IMM, 5'd18, 5'd1,  5'd17, 1'b1},
            '{OPC_LOAD,   5'd19, 5'd1,  5'd0,  1'b0},
            '{OPC_LUI,    5'd4,  5'd19, 5'd19, 1'b0},
            '{OPC_JAL,    5'd1,  5'd19, 5'd19, 1'b1}
        };
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_idle();
        end
        for (int k = 0; k < NUM_ENTRIES; k++) begin
            if (!timed_out) begin
                send(stim[k].opc, stim[k].rd, stim[k].rs1, stim[k].rs2);
            end
            if (stim[k].group_end) begin
                repeat (2) begin
                    if (!timed_out) begin
                        send_filler();
                    end
                end
            end
        end
        if (!timed_out) begin
            drain();
        end
        $display("checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
                 checks, errors, timeouts, dut_i.hazard_chk_i.fail_count);
        if (errors == 0 && timeouts == 0 && dut_i.hazard_chk_i.fail_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* verilog/hazard_pkg.sv */
package hazard_pkg;

    // width of a register address, x0 to x31
    localparam int REG_ADDR_WIDTH = 5;

    // major opcodes of the RV64I formats that the hazard logic looks at
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b000_0011,
        OPC_STORE  = 7'b010_0011,
        OPC_BRANCH = 7'b110_0011,
        OPC_OP_IMM = 7'b001_0011,
        OPC_OP     = 7'b011_0011,
        OPC_LUI    = 7'b011_0111,
        OPC_JAL    = 7'b110_1111
    } opcode_e;

    // classification of an instruction as seen by the hazard unit
    // only CLS_LOAD produces a result that cannot be forwarded in time
    typedef enum logic [2:0] {
        CLS_NONE   = 3'd0,
        CLS_ALU    = 3'd1,
        CLS_LOAD   = 3'd2,
        CLS_STORE  = 3'd3,
        CLS_BRANCH = 3'd4
    } op_class_e;

endpackage

/* verilog/hazard_top.sv */
module hazard_top import hazard_pkg::*; #(
    parameter int LOAD_LATENCY = 1
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      instr_valid,
    input  logic [31:0]               instr,
    input  logic [63:0]               pc,
    output logic                      fetch_hold,
    output logic                      issue_valid,
    output logic [63:0]               issue_pc,
    output logic [REG_ADDR_WIDTH-1:0] issue_rd,
    output op_class_e                 issue_class
);

    logic                      id_valid;
    logic [31:0]               id_instr;
    logic [63:0]               id_pc;
    logic [REG_ADDR_WIDTH-1:0] rs1;
    logic [REG_ADDR_WIDTH-1:0] rs2;
    logic [REG_ADDR_WIDTH-1:0] rd;
    logic                      use_rs1;
    logic                      use_rs2;
    logic                      writes_rd;
    op_class_e                 op_class;
    logic                      ex_valid;
    logic [REG_ADDR_WIDTH-1:0] ex_rd;
    logic                      ex_load;
    logic                      mem_valid;
    logic [REG_ADDR_WIDTH-1:0] mem_rd;
    logic                      mem_load;
    logic                      stall;

    id_stage_reg id_stage_reg_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .stall       (stall),
        .id_valid    (id_valid),
        .id_instr    (id_instr),
        .id_pc       (id_pc)
    );

    instr_decode instr_decode_i (
        .id_instr  (id_instr),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .use_rs1   (use_rs1),
        .use_rs2   (use_rs2),
        .writes_rd (writes_rd),
        .op_class  (op_class)
    );

    id_stall #(
        .LOAD_LATENCY (LOAD_LATENCY)
    ) id_stall_i (
        .id_valid  (id_valid),
        .rs1       (rs1),
        .rs2       (rs2),
        .use_rs1   (use_rs1),
        .use_rs2   (use_rs2),
        .ex_valid  (ex_valid),
        .ex_rd     (ex_rd),
        .ex_load   (ex_load),
        .mem_valid (mem_valid),
        .mem_rd    (mem_rd),
        .mem_load  (mem_load),
        .stall     (stall)
    );

    pending_writes #(
        .LOAD_LATENCY (LOAD_LATENCY)
    ) pending_writes_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall       (stall),
        .id_valid    (id_valid),
        .id_pc       (id_pc),
        .rd          (rd),
        .writes_rd   (writes_rd),
        .op_class    (op_class),
        .ex_valid    (ex_valid),
        .ex_rd       (ex_rd),
        .ex_load     (ex_load),
        .mem_valid   (mem_valid),
        .mem_rd      (mem_rd),
        .mem_load    (mem_load),
        .issue_valid (issue_valid),
        .issue_pc    (issue_pc),
        .issue_rd    (issue_rd),
        .issue_class (issue_class)
    );

    // a stalled ID stage also asks fetch to hold its word
    assign fetch_hold = stall;

endmodule

/* verilog/id_stage_reg.sv */
module id_stage_reg (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        instr_valid,
    input  logic [31:0] instr,
    input  logic [63:0] pc,
    input  logic        stall,
    output logic        id_valid,
    output logic [31:0] id_instr,
    output logic [63:0] id_pc
);

    // the valid bit is the only control state of the stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_valid <= 1'b0;
        end else if (!stall) begin
            id_valid <= instr_valid;
        end
    end

    // instruction word and pc are held while the stage is stalled
    // fetch keeps its outputs steady during fetch_hold, so nothing is lost
    always_ff @(posedge clk) begin
        if (!stall) begin
            id_instr <= instr;
            id_pc    <= pc;
        end
    end

endmodule

/* verilog/id_stall.sv */
module id_stall import hazard_pkg::*; #(
    parameter int LOAD_LATENCY = 1
) (
    input  logic                      id_valid,
    input  logic [REG_ADDR_WIDTH-1:0] rs1,
    input  logic [REG_ADDR_WIDTH-1:0] rs2,
    input  logic                      use_rs1,
    input  logic                      use_rs2,
    input  logic                      ex_valid,
    input  logic [REG_ADDR_WIDTH-1:0] ex_rd,
    input  logic                      ex_load,
    input  logic                      mem_valid,
    input  logic [REG_ADDR_WIDTH-1:0] mem_rd,
    input  logic                      mem_load,
    output logic                      stall
);

    logic rs1_live;
    logic rs2_live;
    logic ex_pending;
    logic mem_pending;
    logic ex_hit;
    logic mem_hit;

    // only loads in the latency window matter since ALU results are forwarded
    generate
        if (LOAD_LATENCY != 1 && LOAD_LATENCY != 2) begin : g_bad_latency
            $error("id_stall: LOAD_LATENCY must be 1 or 2");
        end
    endgenerate

    // x0 is hardwired to zero and is never waited for
    assign rs1_live = use_rs1 && (rs1 != '0);
    assign rs2_live = use_rs2 && (rs2 != '0);

    assign ex_pending  = ex_valid && ex_load;
    assign mem_pending = mem_valid && mem_load && (LOAD_LATENCY == 2);

    assign ex_hit = ex_pending &&
                    ((rs1_live && (rs1 == ex_rd)) || (rs2_live && (rs2 == ex_rd)));

    assign mem_hit = mem_pending &&
                     ((rs1_live && (rs1 == mem_rd)) || (rs2_live && (rs2 == mem_rd)));

    // held for as many cycles as the producing load stays in the window
    assign stall = id_valid && (ex_hit || mem_hit);

endmodule

/* verilog/instr_decode.sv */
module instr_decode import hazard_pkg::*; (
    input  logic [31:0]               id_instr,
    output logic [REG_ADDR_WIDTH-1:0] rs1,
    output logic [REG_ADDR_WIDTH-1:0] rs2,
    output logic [REG_ADDR_WIDTH-1:0] rd,
    output logic                      use_rs1,
    output logic                      use_rs2,
    output logic                      writes_rd,
    output op_class_e                 op_class
);

    opcode_e opcode;

    // register fields sit at the same place in every format
    assign rs1    = id_instr[19:15];
    assign rs2    = id_instr[24:20];
    assign rd     = id_instr[11:7];
    assign opcode = opcode_e'(id_instr[6:0]);

    // the use flags are the single place where a source is qualified,
    // the stall unit trusts them as they are
    always_comb begin
        op_class  = CLS_NONE;
        use_rs1   = 1'b0;
        use_rs2   = 1'b0;
        writes_rd = 1'b0;
        case (opcode)
            OPC_LOAD: begin
                op_class  = CLS_LOAD;
                use_rs1   = 1'b1;
                writes_rd = 1'b1;
            end
            OPC_OP_IMM: begin
                // I-type, the rs2 field holds immediate bits
                op_class  = CLS_ALU;
                use_rs1   = 1'b1;
                writes_rd = 1'b1;
            end
            OPC_OP: begin
                op_class  = CLS_ALU;
                use_rs1   = 1'b1;
                use_rs2   = 1'b1;
                writes_rd = 1'b1;
            end
            OPC_STORE: begin
                // rs2 carries the store data, bits 11:7 are immediate
                op_class = CLS_STORE;
                use_rs1  = 1'b1;
                use_rs2  = 1'b1;
            end
            OPC_BRANCH: begin
                op_class = CLS_BRANCH;
                use_rs1  = 1'b1;
                use_rs2  = 1'b1;
            end
            OPC_LUI: begin
                op_class  = CLS_ALU;
                writes_rd = 1'b1;
            end
            OPC_JAL: begin
                // the link value is ready in EX like any ALU result
                op_class  = CLS_ALU;
                writes_rd = 1'b1;
            end
            default: begin
                op_class  = CLS_NONE;
                use_rs1   = 1'b0;
                use_rs2   = 1'b0;
                writes_rd = 1'b0;
            end
        endcase
    end

endmodule

/* verilog/pending_writes.sv */
module pending_writes import hazard_pkg::*; #(
    parameter int LOAD_LATENCY = 1
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      stall,
    input  logic                      id_valid,
    input  logic [63:0]               id_pc,
    input  logic [REG_ADDR_WIDTH-1:0] rd,
    input  logic                      writes_rd,
    input  op_class_e                 op_class,
    output logic                      ex_valid,
    output logic [REG_ADDR_WIDTH-1:0] ex_rd,
    output logic                      ex_load,
    output logic                      mem_valid,
    output logic [REG_ADDR_WIDTH-1:0] mem_rd,
    output logic                      mem_load,
    output logic                      issue_valid,
    output logic [63:0]               issue_pc,
    output logic [REG_ADDR_WIDTH-1:0] issue_rd,
    output op_class_e                 issue_class
);

    logic        issue_now;
    logic [63:0] ex_pc;
    op_class_e   ex_class;

    // a stalled or empty ID stage sends a bubble into EX
    assign issue_now = id_valid && !stall;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
            ex_load  <= 1'b0;
        end else begin
            ex_valid <= issue_now;
            ex_load  <= issue_now && (op_class == CLS_LOAD);
        end
    end

    // rd is stored as x0 when nothing is written,
    // and x0 never matches a source in the stall unit
    always_ff @(posedge clk) begin
        ex_rd    <= writes_rd ? rd : '0;
        ex_pc    <= id_pc;
        ex_class <= op_class;
    end

    generate
        if (LOAD_LATENCY == 2) begin : g_mem_slot
            // load data still missing while the load sits in MEM
            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    mem_valid <= 1'b0;
                    mem_load  <= 1'b0;
                end else begin
                    mem_valid <= ex_valid;
                    mem_load  <= ex_load;
                end
            end

            always_ff @(posedge clk) begin
                mem_rd <= ex_rd;
            end
        end else begin : g_no_mem_slot
            // load data is forwardable once the load leaves EX
            assign mem_valid = 1'b0;
            assign mem_load  = 1'b0;
            assign mem_rd    = '0;
        end
    endgenerate

    // the issue port shows what entered EX this cycle
    assign issue_valid = ex_valid;
    assign issue_pc    = ex_pc;
    assign issue_rd    = ex_rd;
    assign issue_class = ex_class;

endmodule
